// ==== Makefile ====
# Verilator build and run of the fetch front end testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f src.f --top-module fetch_unit_tb \
		-Mdir obj_dir -o fetch_unit_tb
	./obj_dir/fetch_unit_tb

clean:
	rm -rf obj_dir

// ==== design/fetch_pkg.sv ====
// shared widths, opcodes and the instruction word union
// for the rv32 fetch front end

`default_nettype none

package fetch_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int unsigned XLEN   = 32;
    // queue entry is {pc, instruction word}
    localparam int unsigned QENT_W = 2 * XLEN;

    // ----------------------------------------
    // major opcodes
    // ----------------------------------------
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // one instruction word, seen as j-format or b-format
    typedef union packed {
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_view;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_view;
    } instr_u;

endpackage

`default_nettype wire

// ==== design/fetch_unit.sv ====
// fetch front end top: pc generator, fetch queue and predecode
// between instruction memory and dispatch

`default_nettype none

module fetch_unit
    import fetch_pkg::*;
#(
    parameter int unsigned     DEPTH_X  = 2,
    parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  logic            clk_i,
    input  logic            clk_en_i,
    input  logic            resetb_i,
    // trap or mispredict from later stages
    input  logic            flush_i,
    input  logic [XLEN-1:0] flush_pc_i,
    // instruction memory, one cycle latency
    output logic            imem_req_o,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [XLEN-1:0] imem_rdata_i,
    // dispatch side
    input  logic            take_i,
    output logic            instr_valid_o,
    output instr_u          instr_o,
    output logic [XLEN-1:0] pc_o,
    output logic            is_jal_o,
    output logic            is_branch_o,
    output logic [XLEN-1:0] target_o
);

    // ----------------------------------------
    // internal nets
    // ----------------------------------------
    logic              redirect;
    logic [XLEN-1:0]   redirect_pc;
    logic              pop;
    logic              q_wr;
    logic [XLEN-1:0]   q_pc;
    logic              q_empty;
    logic [QENT_W-1:0] q_head;

    assign instr_valid_o = ~q_empty;

    // request side
    pc_gen #(
        .DEPTH_X  (DEPTH_X),
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk_i         (clk_i),
        .clk_en_i      (clk_en_i),
        .resetb_i      (resetb_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .pop_i         (pop),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .q_wr_o        (q_wr),
        .q_pc_o        (q_pc)
    );

    // queue entry pairs returned word with its pc, full unused
    fifo #(
        .WIDTH   (QENT_W),
        .DEPTH_X (DEPTH_X)
    ) u_fifo (
        .clk_i    (clk_i),
        .clk_en_i (clk_en_i),
        .resetb_i (resetb_i),
        .flush_i  (redirect),
        .empty_o  (q_empty),
        .full_o   (),
        .wr_i     (q_wr),
        .din_i    ({q_pc, imem_rdata_i}),
        .rd_i     (pop),
        .dout_o   (q_head)
    );

    // head decode and redirect select
    predecode u_predecode (
        .clk_i         (clk_i),
        .clk_en_i      (clk_en_i),
        .resetb_i      (resetb_i),
        .flush_i       (flush_i),
        .flush_pc_i    (flush_pc_i),
        .empty_i       (q_empty),
        .head_i        (q_head),
        .take_i        (take_i),
        .pop_o         (pop),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .instr_o       (instr_o),
        .pc_o          (pc_o),
        .is_jal_o      (is_jal_o),
        .is_branch_o   (is_branch_o),
        .target_o      (target_o)
    );

endmodule

`default_nettype wire

// ==== design/fifo.sv ====
// fetch queue: pointer based fifo with flush and clock enable
// plus overflow and underflow checks

`default_nettype none

module fifo #(
    parameter int unsigned WIDTH   = 1,
    parameter int unsigned DEPTH_X = 1
) (
    // clocking
    input  logic             clk_i,
    input  logic             clk_en_i,
    input  logic             resetb_i,
    // control and status
    input  logic             flush_i,
    output logic             empty_o,
    output logic             full_o,
    // write side
    input  logic             wr_i,
    input  logic [WIDTH-1:0] din_i,
    // read side
    input  logic             rd_i,
    output logic [WIDTH-1:0] dout_o
);

    localparam int unsigned DEPTH = 2 ** DEPTH_X;

    // ----------------------------------------
    // storage and pointers
    // ----------------------------------------
    // top bit of each pointer is the wrap flag
    logic [DEPTH_X:0] rd_ptr_q;
    logic [DEPTH_X:0] wr_ptr_q;
    logic [WIDTH-1:0] mem_q [DEPTH];

    // head entry, read without a register stage
    assign dout_o = mem_q[rd_ptr_q[DEPTH_X-1:0]];

    // same slot: equal wrap bits mean empty, different mean full
    always_comb begin
        empty_o = 1'b0;
        full_o  = 1'b0;
        if (rd_ptr_q[DEPTH_X-1:0] == wr_ptr_q[DEPTH_X-1:0]) begin
            if (rd_ptr_q[DEPTH_X] == wr_ptr_q[DEPTH_X]) begin
                empty_o = 1'b1;
            end else begin
                full_o = 1'b1;
            end
        end
    end

    // pointer update, flush drops every entry
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
        end else if (clk_en_i) begin
            if (flush_i) begin
                rd_ptr_q <= '0;
                wr_ptr_q <= '0;
            end else begin
                if (rd_i) begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
                if (wr_i) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
        end
    end

    // data array
    always_ff @(posedge clk_i) begin
        if (clk_en_i && wr_i) begin
            mem_q[wr_ptr_q[DEPTH_X-1:0]] <= din_i;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // pc_gen credits must keep writes away from a full queue
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        clk_en_i |-> !(full_o && wr_i)
    ) else $error("fifo written while full");

    // predecode masks takes, so no pop on an empty queue
    a_no_underflow : assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        clk_en_i |-> !(empty_o && rd_i)
    ) else $error("fifo read while empty");

endmodule

`default_nettype wire

// ==== design/pc_gen.sv ====
// pc generator: next fetch pc, queue credits and in-flight read
// tracking, issues imem requests and the queue write strobe

`default_nettype none

module pc_gen
    import fetch_pkg::*;
#(
    parameter int unsigned     DEPTH_X  = 2,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            clk_en_i,
    input  logic            resetb_i,
    // redirect from predecode or external flush
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    // queue pop, returns one credit
    input  logic            pop_i,
    // instruction memory request
    output logic            imem_req_o,
    output logic [XLEN-1:0] imem_addr_o,
    // queue write side
    output logic            q_wr_o,
    output logic [XLEN-1:0] q_pc_o
);

    localparam int unsigned      DEPTH    = 2 ** DEPTH_X;
    localparam logic [DEPTH_X:0] CRED_MAX = (DEPTH_X + 1)'(DEPTH);
    localparam logic [DEPTH_X:0] CRED_ONE = (DEPTH_X + 1)'(1);

    // ----------------------------------------
    // state
    // ----------------------------------------
    logic [XLEN-1:0] pc_q;
    // free queue slots not yet claimed by a request
    logic [DEPTH_X:0] credit_q;
    logic [DEPTH_X:0] credit_d;
    // read issued last enabled cycle, data due now
    logic            pend_q;
    logic [XLEN-1:0] pend_pc_q;

    // request whenever a slot is free
    assign imem_req_o  = (credit_q != '0);
    assign imem_addr_o = pc_q;

    // returned word goes into the queue unless killed this cycle
    assign q_wr_o = pend_q & ~redirect_i;
    assign q_pc_o = pend_pc_q;

    // spend one per request, get one back per pop
    always_comb begin
        credit_d = credit_q;
        if (imem_req_o) begin
            credit_d = credit_d - CRED_ONE;
        end
        if (pop_i) begin
            credit_d = credit_d + CRED_ONE;
        end
    end

    // control state
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            pc_q     <= RESET_PC;
            credit_q <= CRED_MAX;
            pend_q   <= 1'b0;
        end else if (clk_en_i) begin
            if (redirect_i) begin
                // restart at new pc, queue is flushed so all credits back
                pc_q     <= redirect_pc_i;
                credit_q <= CRED_MAX;
                // any read in flight is dropped
                pend_q   <= 1'b0;
            end else begin
                if (imem_req_o) begin
                    pc_q <= pc_q + XLEN'(4);
                end
                credit_q <= credit_d;
                pend_q   <= imem_req_o;
            end
        end
    end

    // address travelling with the pending read
    always_ff @(posedge clk_i) begin
        if (clk_en_i && imem_req_o) begin
            pend_pc_q <= pc_q;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_credit_range : assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        credit_q <= CRED_MAX
    ) else $error("credits above queue depth");

endmodule

`default_nettype wire

// ==== design/predecode.sv ====
// predecode of the fetch queue head: jal / branch class,
// static target, pop strobe and redirect request

`default_nettype none

module predecode
    import fetch_pkg::*;
(
    // clocking, used by the checks only
    input  logic              clk_i,
    input  logic              clk_en_i,
    input  logic              resetb_i,
    // external redirect
    input  logic              flush_i,
    input  logic [XLEN-1:0]   flush_pc_i,
    // queue head
    input  logic              empty_i,
    input  logic [QENT_W-1:0] head_i,
    // dispatch
    input  logic              take_i,
    output logic              pop_o,
    // redirect to pc_gen and fifo
    output logic              redirect_o,
    output logic [XLEN-1:0]   redirect_pc_o,
    // decoded head
    output instr_u            instr_o,
    output logic [XLEN-1:0]   pc_o,
    output logic              is_jal_o,
    output logic              is_branch_o,
    output logic [XLEN-1:0]   target_o
);

    // ----------------------------------------
    // head split and offsets
    // ----------------------------------------
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] b_imm;
    logic            jal_taken;

    // pc in the upper half, word in the lower
    assign pc_o    = head_i[QENT_W-1:XLEN];
    assign instr_o = head_i[XLEN-1:0];

    // opcode sits in the same bits for both views
    assign is_jal_o    = (instr_o.j_view.opcode == OPC_JAL);
    assign is_branch_o = (instr_o.b_view.opcode == OPC_BRANCH);

    // j-format: 21 bit offset, bit 0 implied zero
    assign j_imm = {{11{instr_o.j_view.imm20}},
                    instr_o.j_view.imm20,
                    instr_o.j_view.imm19_12,
                    instr_o.j_view.imm11,
                    instr_o.j_view.imm10_1,
                    1'b0};

    // b-format: 13 bit offset, bit 0 implied zero
    assign b_imm = {{19{instr_o.b_view.imm12}},
                    instr_o.b_view.imm12,
                    instr_o.b_view.imm11,
                    instr_o.b_view.imm10_5,
                    instr_o.b_view.imm4_1,
                    1'b0};

    // static target, fall through for everything else
    always_comb begin
        if (is_jal_o) begin
            target_o = pc_o + j_imm;
        end else if (is_branch_o) begin
            target_o = pc_o + b_imm;
        end else begin
            target_o = pc_o + XLEN'(4);
        end
    end

    // ----------------------------------------
    // pop and redirect
    // ----------------------------------------
    // a take only counts with a valid head
    assign pop_o     = take_i & ~empty_i;
    assign jal_taken = pop_o & is_jal_o;

    // external flush has priority over the jal target
    assign redirect_o    = flush_i | jal_taken;
    assign redirect_pc_o = flush_i ? flush_pc_i : target_o;

    // dispatch must only take a valid instruction
    a_take_valid : assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        clk_en_i |-> !(take_i && empty_i)
    ) else $error("take while queue empty");

endmodule

`default_nettype wire

// ==== sim/fetch_golden.txt ====
// header: memory pairs, flush events, expected entries
// then memory (addr data), flushes (entry index, flush pc), stream (pc word class)
// class 0 other, 1 jal, 2 branch
001B 0002 0015
// memory image
00000100 00108093
00000104 00208093
00000108 0040006F
0000010C 00308093
00000110 00208463
00000114 0100006F
00000118 00408093
0000011C 00508093
00000120 00608093
00000124 00708093
00000128 FE209CE3
0000012C 0D40006F
00000130 00808093
000001E4 00A08093
000001E8 0200006F
00000200 00908093
00000204 FE1FF06F
00000208 00B08093
0000020C 00C08093
00000210 00D08093
00000300 0080006F
00000308 00E08093
00000400 00F08093
00000404 01008093
00000408 01108093
0000040C 01208093
00000410 01308093
// flush events
0000000E 00000300
0000000F 00000400
// expected stream
00000100 00108093 0
00000104 00208093 0
00000108 0040006F 1
0000010C 00308093 0
00000110 00208463 2
00000114 0100006F 1
00000124 00708093 0
00000128 FE209CE3 2
0000012C 0D40006F 1
00000200 00908093 0
00000204 FE1FF06F 1
000001E4 00A08093 0
000001E8 0200006F 1
00000208 00B08093 0
0000020C 00C08093 0
00000300 0080006F 1
00000400 00F08093 0
00000404 01008093 0
00000408 01108093 0
0000040C 01208093 0
00000410 01308093 0

// ==== sim/fetch_unit_tb.sv ====
// testbench for the fetch front end: memory model, golden file reader,
// random dispatch and stall stimulus, stream checks and timeout

`default_nettype none

module fetch_unit_tb
    import fetch_pkg::*;
();

    localparam logic [XLEN-1:0] START_PC = 32'h0000_0100;
    localparam int              MEM_WORDS = 1024;

    // ----------------------------------------
    // dut signals
    // ----------------------------------------
    logic            clk_i;
    logic            clk_en_i;
    logic            resetb_i;
    logic            flush_i;
    logic [XLEN-1:0] flush_pc_i;
    logic            imem_req_o;
    logic [XLEN-1:0] imem_addr_o;
    logic [XLEN-1:0] imem_rdata_i;
    logic            take_i;
    logic            instr_valid_o;
    instr_u          instr_o;
    logic [XLEN-1:0] pc_o;
    logic            is_jal_o;
    logic            is_branch_o;
    logic [XLEN-1:0] target_o;

    // ----------------------------------------
    // golden data and tb state
    // ----------------------------------------
    logic [31:0] gold [0:255];
    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] exp_pc [0:63];
    logic [31:0] exp_word [0:63];
    logic [1:0]  exp_cls [0:63];
    int          fl_key [0:7];
    logic [31:0] fl_pc [0:7];
    int          n_mem;
    int          n_fl;
    int          n_exp;
    int          chk_idx;
    int          fl_idx;
    int          cycles;
    int          limit;
    int          seed;
    logic        run;
    logic        accepted;
    logic        take_next;
    // fetch address due after reset or a redirect
    logic        req_chk;
    logic [31:0] req_pc;
    // outputs seen at a disabled edge, compared one edge later
    logic        hold_chk;
    logic        hold_valid;
    logic        hold_req;
    logic [31:0] hold_addr;
    logic [31:0] hold_pc;
    logic [31:0] hold_instr;
    logic [31:0] hold_target;

    fetch_unit #(
        .DEPTH_X  (2),
        .RESET_PC (START_PC)
    ) UUT (
        .clk_i         (clk_i),
        .clk_en_i      (clk_en_i),
        .resetb_i      (resetb_i),
        .flush_i       (flush_i),
        .flush_pc_i    (flush_pc_i),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .take_i        (take_i),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .pc_o          (pc_o),
        .is_jal_o      (is_jal_o),
        .is_branch_o   (is_branch_o),
        .target_o      (target_o)
    );

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    // compare one value, first mismatch ends the run
    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // rv32 static target from the raw word
    function automatic logic [31:0] ref_target(input logic [31:0] pc,
                                               input logic [31:0] w,
                                               input logic [1:0]  cls);
        logic [31:0] imm;
        imm = 32'd4;
        if (cls == 2'd1) begin
            imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end else if (cls == 2'd2) begin
            imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        return pc + imm;
    endfunction

    // head against the next golden entry
    task automatic check_head(input int idx);
        check_val("pc_o", pc_o, exp_pc[idx]);
        check_val("instr_o", instr_o, exp_word[idx]);
        check_val("is_jal_o", 32'(is_jal_o), 32'(exp_cls[idx] == 2'd1));
        check_val("is_branch_o", 32'(is_branch_o), 32'(exp_cls[idx] == 2'd2));
        check_val("target_o", target_o,
                  ref_target(exp_pc[idx], exp_word[idx], exp_cls[idx]));
    endtask

    // stream done, every flush event must have been used
    task automatic end_run();
        if (fl_idx == n_fl) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("stream ended with %0d flush events not applied", n_fl - fl_idx);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // ----------------------------------------
    // golden file and memory image
    // ----------------------------------------
    initial begin
        int p;
        $readmemh("sim/fetch_golden.txt", gold);
        n_mem = int'(gold[0]);
        n_fl  = int'(gold[1]);
        n_exp = int'(gold[2]);
        // unmapped words are addi with the word index in the immediate
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[11:0], 13'd0, 7'h13};
        end
        p = 3;
        for (int i = 0; i < n_mem; i++) begin
            mem[gold[p][11:2]] = gold[p+1];
            p = p + 2;
        end
        for (int i = 0; i < n_fl; i++) begin
            fl_key[i] = int'(gold[p]);
            fl_pc[i]  = gold[p+1];
            p = p + 2;
        end
        for (int i = 0; i < n_exp; i++) begin
            exp_pc[i]   = gold[p];
            exp_word[i] = gold[p+1];
            exp_cls[i]  = gold[p+2][1:0];
            p = p + 3;
        end
        limit = 10 * n_exp + 200;
    end

    // ----------------------------------------
    // clock, reset and memory model
    // ----------------------------------------
    initial begin
        clk_i = 1'b0;
        forever begin
            #20 clk_i = ~clk_i;
        end
    end

    initial begin
        seed         = 32'h8526_8bba;
        resetb_i     = 1'b0;
        clk_en_i     = 1'b1;
        flush_i      = 1'b0;
        flush_pc_i   = '0;
        take_i       = 1'b0;
        imem_rdata_i = '0;
        run          = 1'b0;
        hold_chk     = 1'b0;
        // first request goes out to the reset pc
        req_chk      = 1'b1;
        req_pc       = START_PC;
        chk_idx      = 0;
        fl_idx       = 0;
        cycles       = 0;
        repeat (10) @(posedge clk_i);
        resetb_i <= 1'b1;
        run      <= 1'b1;
    end

    // one cycle latency, response held while stalled
    always @(posedge clk_i) begin
        if (clk_en_i && imem_req_o) begin
            imem_rdata_i <= mem[imem_addr_o[11:2]];
        end
    end

    // ----------------------------------------
    // checking and dispatch stimulus
    // ----------------------------------------
    always @(posedge clk_i) begin
        if (run) begin
            cycles = cycles + 1;
            if (cycles >= limit) begin
                $display("timeout after %0d cycles with %0d of %0d entries checked",
                         cycles, chk_idx, n_exp);
                $display("CHECKS FAILED");
                $fatal(1);
            end else begin
                // a disabled cycle must leave the outputs alone
                if (hold_chk) begin
                    check_val("instr_valid_o", 32'(instr_valid_o), 32'(hold_valid));
                    check_val("imem_req_o", 32'(imem_req_o), 32'(hold_req));
                    check_val("imem_addr_o", imem_addr_o, hold_addr);
                    check_val("pc_o", pc_o, hold_pc);
                    check_val("instr_o", instr_o, hold_instr);
                    check_val("target_o", target_o, hold_target);
                end
                // new fetch pc requested in the cycle after the redirect
                if (req_chk) begin
                    check_val("imem_req_o", 32'(imem_req_o), 32'd1);
                    check_val("imem_addr_o", imem_addr_o, req_pc);
                end
                req_chk = 1'b0;
                hold_chk = !clk_en_i;
                hold_valid  = instr_valid_o;
                hold_req    = imem_req_o;
                hold_addr   = imem_addr_o;
                hold_pc     = pc_o;
                hold_instr  = instr_o;
                hold_target = target_o;
                accepted = clk_en_i && take_i && instr_valid_o;
                if (accepted) begin
                    check_head(chk_idx);
                    // flush was driven together with this take
                    if (flush_i) begin
                        fl_idx  = fl_idx + 1;
                        req_chk = 1'b1;
                        req_pc  = flush_pc_i;
                    end else if (exp_cls[chk_idx] == 2'd1) begin
                        req_chk = 1'b1;
                        req_pc  = ref_target(exp_pc[chk_idx], exp_word[chk_idx], 2'd1);
                    end
                    chk_idx = chk_idx + 1;
                end
                if (chk_idx == n_exp) begin
                    end_run();
                end else begin
                    // head after this edge is known valid only without a pop
                    take_next = (($random(seed) & 3) != 0) && instr_valid_o && !accepted;
                    clk_en_i <= (($random(seed) & 3) != 0);
                    take_i   <= take_next;
                    if (take_next && fl_idx < n_fl && fl_key[fl_idx] == chk_idx) begin
                        flush_i    <= 1'b1;
                        flush_pc_i <= fl_pc[fl_idx];
                    end else begin
                        flush_i    <= 1'b0;
                        flush_pc_i <= '0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/fetch_pkg.sv
design/fifo.sv
design/pc_gen.sv
design/predecode.sv
design/fetch_unit.sv
sim/fetch_unit_tb.sv
